// ==== Makefile ====
TOP := exec_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir

// ==== bench/exec_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module exec_core_tb
    import reg_pkg::*;
    import op_pkg::*;
();

    // about 290 cycles of stimulus plus margin
    localparam int MAX_CYCLES   = 400;
    localparam int RANDOM_COUNT = 200;

    logic    clk_i;
    logic    rst_i;
    issue_t  issue_i;
    retire_t retire_o;

    // architectural view of registers 0 to 14
    word_t shadow [`REG_COUNT];

    // expected retires in issue order, with the name of the test that issued them
    retire_t expected_q [$];
    string   name_q [$];

    retire_t expected;
    string   exp_name;
    integer  seed;
    int      cycle_count;
    int      error_count;
    word_t   next_pc;

    exec_core exec_core_inst (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .issue_i  (issue_i),
        .retire_o (retire_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #2 clk_i = ~clk_i;
        end
    end

    // register 15 reads as the instruction's own address
    function automatic word_t read_reg(input reg_addr_t addr, input word_t pc);
        if (addr == `PC_REG) begin
            return pc;
        end
        return shadow[addr];
    endfunction

    // one instruction completed in program order
    function automatic retire_t model_exec(input issue_t ins);
        word_t   op_n;
        word_t   op_2;
        retire_t res;
        op_n = read_reg(ins.rn, ins.pc);
        op_2 = ins.use_imm ? ins.imm : read_reg(ins.rm, ins.pc);
        res.valid = 1'b1;
        res.rd    = ins.rd;
        case (ins.op)
            ADD:     res.data = op_n + op_2;
            SUB:     res.data = op_n - op_2;
            AND:     res.data = op_n & op_2;
            ORR:     res.data = op_n | op_2;
            EOR:     res.data = op_n ^ op_2;
            MOV:     res.data = op_2;
            default: res.data = '0;
        endcase
        // a PC destination is reported, never stored
        if (ins.rd != `PC_REG) begin
            shadow[ins.rd] = res.data;
        end
        return res;
    endfunction

    task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            error_count++;
            $display("Mismatch %s rd: expected %0d actual %0d", name, exp, act);
            $display("RESULT: FAIL");
            $fatal(1, "rd mismatch");
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            error_count++;
            $display("Mismatch %s data: expected %08h actual %08h", name, exp, act);
            $display("RESULT: FAIL");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic issue_one(input string name, input alu_op_e op, input reg_addr_t rd,
                             input reg_addr_t rn, input reg_addr_t rm,
                             input logic use_imm, input word_t imm);
        issue_t ins;
        ins.valid   = 1'b1;
        ins.op      = op;
        ins.rd      = rd;
        ins.rn      = rn;
        ins.rm      = rm;
        ins.use_imm = use_imm;
        ins.imm     = imm;
        ins.pc      = next_pc;
        next_pc = next_pc + 32'd4;
        expected_q.push_back(model_exec(ins));
        name_q.push_back(name);
        issue_i = ins;
        @(posedge clk_i);
        #1;
    endtask

    task automatic idle_cycle();
        issue_i.valid = 1'b0;
        @(posedge clk_i);
        #1;
    endtask

    // outputs settle after the rising edge, sample them mid-cycle
    always @(negedge clk_i) begin
        if (!rst_i && retire_o.valid) begin
            if (expected_q.size() == 0) begin
                $display("a result retired while no instruction was outstanding");
                $display("RESULT: FAIL");
                $fatal(1, "unexpected retire");
            end else begin
                expected = expected_q.pop_front();
                exp_name = name_q.pop_front();
                check_addr(exp_name, expected.rd, retire_o.rd);
                check_word(exp_name, expected.data, retire_o.data);
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout after %0d cycles with %0d results outstanding",
                     cycle_count, expected_q.size());
            $display("RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    initial begin
        seed        = 89163;
        next_pc     = 32'h0000_1000;
        error_count = 0;
        cycle_count = 0;
        rst_i       = 1'b1;
        issue_i     = '0;
        repeat (4) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        for (int r = 0; r < 15; r++) begin
            issue_one("init", MOV, reg_addr_t'(r), 4'd0, 4'd0, 1'b1, 32'hc0de_0000 | word_t'(r));
        end

        // every operation, register and immediate form
        for (int k = 0; k < 6; k++) begin
            issue_one("op_reg", alu_op_e'(3'(k)), 4'd10, 4'd1, 4'd2, 1'b0, 32'h0);
            issue_one("op_imm", alu_op_e'(3'(k)), 4'd11, 4'd3, 4'd4, 1'b1, 32'h0f0f_1234);
        end

        // each one reads the rd of the one before
        issue_one("chain", ADD, 4'd5, 4'd5, 4'd6, 1'b1, 32'h1);
        issue_one("chain", ADD, 4'd5, 4'd5, 4'd6, 1'b0, 32'h0);
        issue_one("chain", SUB, 4'd7, 4'd5, 4'd8, 1'b0, 32'h0);
        issue_one("chain", EOR, 4'd8, 4'd9, 4'd7, 1'b0, 32'h0);
        issue_one("chain", ORR, 4'd9, 4'd8, 4'd8, 1'b0, 32'h0);
        issue_one("chain", AND, 4'd6, 4'd9, 4'd9, 1'b1, 32'hffff_00ff);
        issue_one("chain", MOV, 4'd1, 4'd0, 4'd6, 1'b0, 32'h0);

        // consumer two slots behind its producer
        for (int k = 0; k < 4; k++) begin
            issue_one("distance_two", ADD, 4'd12, 4'd12, 4'd1, 1'b0, 32'h0);
            issue_one("distance_two", MOV, 4'd13, 4'd0, 4'd0, 1'b1, word_t'(k));
            issue_one("distance_two", SUB, 4'd14, 4'd3, 4'd12, 1'b0, 32'h0);
        end

        issue_one("pc_read", ADD, 4'd2, 4'd15, 4'd0, 1'b1, 32'h0);
        issue_one("pc_read", EOR, 4'd3, 4'd4, 4'd15, 1'b0, 32'h0);
        issue_one("pc_write", MOV, 4'd15, 4'd0, 4'd0, 1'b1, 32'hdead_0000);
        issue_one("pc_after_write", ADD, 4'd4, 4'd15, 4'd0, 1'b1, 32'h8);
        idle_cycle();
        idle_cycle();
        issue_one("pc_after_write", ORR, 4'd5, 4'd15, 4'd15, 1'b0, 32'h0);

        for (int n = 0; n < RANDOM_COUNT; n++) begin
            if (($unsigned($random(seed)) % 8) == 0) begin
                idle_cycle();
            end
            issue_one("random", alu_op_e'(3'($unsigned($random(seed)) % 6)),
                      reg_addr_t'($random(seed)), reg_addr_t'($random(seed)),
                      reg_addr_t'($random(seed)), 1'($random(seed)),
                      word_t'($random(seed)));
        end

        issue_i = '0;
        while (expected_q.size() != 0) begin
            @(posedge clk_i);
        end
        repeat (3) @(posedge clk_i);
        if (error_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("RESULT: FAIL");
            $fatal(1, "checks failed");
        end
    end

endmodule

`default_nettype wire

// ==== design/alu_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module alu_stage
    import reg_pkg::*;
    import op_pkg::*;
(
    input  wire logic   clk_i,
    input  wire logic   rst_i,
    input  wire issue_t issue_i,
    input  wire word_t  reg_data_1_i,
    input  wire word_t  reg_data_2_i,
    output reg_write_t  write_o,
    output retire_t     retire_o
);

    issue_t  issue_q;
    retire_t retire_q;

    word_t op_n;
    word_t op_m;
    word_t op_2;
    word_t result;

    // previous result still in flight, newer than anything the register file holds
    function automatic logic bypass_hit(input reg_addr_t addr, input retire_t prev);
        return prev.valid && (prev.rd == addr) && (addr != `PC_REG);
    endfunction

    always_ff @(posedge clk_i) begin
        issue_q <= issue_i;
        if (rst_i) begin
            issue_q.valid <= 1'b0;
        end
    end

    always_comb begin
        op_n = bypass_hit(issue_q.rn, retire_q) ? retire_q.data : reg_data_1_i;
        op_m = bypass_hit(issue_q.rm, retire_q) ? retire_q.data : reg_data_2_i;
        op_2 = issue_q.use_imm ? issue_q.imm : op_m;
    end

    always_comb begin
        case (issue_q.op)
            ADD:     result = op_n + op_2;
            SUB:     result = op_n - op_2;
            AND:     result = op_n & op_2;
            ORR:     result = op_n | op_2;
            EOR:     result = op_n ^ op_2;
            default: result = op_2;
        endcase
    end

    always_ff @(posedge clk_i) begin
        retire_q.valid <= issue_q.valid;
        retire_q.rd    <= issue_q.rd;
        retire_q.data  <= result;
        if (rst_i) begin
            retire_q.valid <= 1'b0;
        end
    end

    // results for the PC are reported only
    assign write_o.enable = retire_q.valid && (retire_q.rd != `PC_REG);
    assign write_o.addr   = retire_q.rd;
    assign write_o.data   = retire_q.data;
    assign retire_o       = retire_q;

    // undefined encodings would silently fall into the MOV branch
    legal_op: assert property (
        @(posedge clk_i) disable iff (rst_i)
        issue_i.valid |-> (issue_i.op inside {ADD, SUB, AND, ORR, EOR, MOV})
    ) else $error("issued instruction carries an undefined ALU operation");

endmodule

`default_nettype wire

// ==== design/clocked_reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module clocked_reg_file
    import reg_pkg::*;
(
    input  wire logic       clk_i,
    input  wire reg_addr_t  read_addr_1_i,
    input  wire reg_addr_t  read_addr_2_i,
    input  wire reg_write_t write_i,
    input  wire word_t      program_counter_i,
    output      word_t      reg_data_1_o,
    output      word_t      reg_data_2_o,
    output      word_t      program_counter_o
);

    // state held for one cycle alongside the RAM read
    reg_addr_t  stored_read_1_addr;
    reg_addr_t  stored_read_2_addr;
    reg_write_t stored_write;
    word_t      stored_pc;

    word_t ram_data_1;
    word_t ram_data_2;

    // pick PC, forwarded write-back or RAM data for one operand
    function automatic word_t select_operand(
        input reg_addr_t  addr,
        input word_t      ram_data,
        input reg_write_t wr,
        input word_t      pc
    );
        word_t operand;
        if (addr == `PC_REG) begin
            operand = pc;
        end else if (wr.enable && (wr.addr == addr)) begin
            operand = wr.data;
        end else begin
            operand = ram_data;
        end
        return operand;
    endfunction

    reg_ram reg_ram_inst (
        .clk_i       (clk_i),
        .rd_addr_1_i (read_addr_1_i),
        .rd_addr_2_i (read_addr_2_i),
        .write_i     (write_i),
        .rd_data_1_o (ram_data_1),
        .rd_data_2_o (ram_data_2)
    );

    always_ff @(posedge clk_i) begin
        stored_read_1_addr <= read_addr_1_i;
        stored_read_2_addr <= read_addr_2_i;
        stored_write       <= write_i;
        stored_pc          <= program_counter_i;
    end

    always_comb begin
        reg_data_1_o = select_operand(stored_read_1_addr, ram_data_1, stored_write, stored_pc);
        reg_data_2_o = select_operand(stored_read_2_addr, ram_data_2, stored_write, stored_pc);
    end

    assign program_counter_o = stored_pc;

endmodule

`default_nettype wire

// ==== design/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// data path width in bits
`define WORD 32

// number of architectural registers
`define REG_COUNT 16

// register index width, log2 of REG_COUNT
`define ADDR_WIDTH 4

// register 15 holds the program counter, it is not stored in the RAM
`define PC_REG (`ADDR_WIDTH'(15))

`endif

// ==== design/exec_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_core
    import reg_pkg::*;
    import op_pkg::*;
(
    input  wire logic    clk_i,
    input  wire logic    rst_i,
    input  wire issue_t  issue_i,
    output      retire_t retire_o
);

    // write-back path from the ALU stage into the register file
    reg_write_t write_back;

    // operands, valid one cycle after issue
    word_t reg_data_1;
    word_t reg_data_2;

    clocked_reg_file clocked_reg_file_inst (
        .clk_i             (clk_i),
        .read_addr_1_i     (issue_i.rn),
        .read_addr_2_i     (issue_i.rm),
        .write_i           (write_back),
        .program_counter_i (issue_i.pc),
        .reg_data_1_o      (reg_data_1),
        .reg_data_2_o      (reg_data_2),
        .program_counter_o ()
    );

    alu_stage alu_stage_inst (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .issue_i      (issue_i),
        .reg_data_1_i (reg_data_1),
        .reg_data_2_i (reg_data_2),
        .write_o      (write_back),
        .retire_o     (retire_o)
    );

endmodule

`default_nettype wire

// ==== design/op_pkg.sv ====
`default_nettype none

package op_pkg;

    import reg_pkg::*;

    // ALU operations
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        ORR = 3'd3,
        EOR = 3'd4,
        MOV = 3'd5
    } alu_op_e;

    // one instruction as it enters the core
    typedef struct packed {
        logic      valid;
        alu_op_e   op;
        reg_addr_t rd;
        reg_addr_t rn;
        reg_addr_t rm;
        // operand 2 comes from imm instead of rm
        logic      use_imm;
        word_t     imm;
        word_t     pc;
    } issue_t;

    // one completed instruction
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } retire_t;

endpackage

`default_nettype wire

// ==== design/reg_pkg.sv ====
`default_nettype none

`include "cpu_consts.svh"

package reg_pkg;

    // one data word
    typedef logic [`WORD-1:0] word_t;

    // register index
    typedef logic [`ADDR_WIDTH-1:0] reg_addr_t;

    // write port record, from the execute stage back into the register file
    typedef struct packed {
        logic      enable;
        reg_addr_t addr;
        word_t     data;
    } reg_write_t;

endpackage

`default_nettype wire

// ==== design/reg_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module reg_ram
    import reg_pkg::*;
(
    input  wire logic       clk_i,
    input  wire reg_addr_t  rd_addr_1_i,
    input  wire reg_addr_t  rd_addr_2_i,
    input  wire reg_write_t write_i,
    output      word_t      rd_data_1_o,
    output      word_t      rd_data_2_o
);

    word_t mem [`REG_COUNT];

    always_ff @(posedge clk_i) begin
        if (write_i.enable) begin
            mem[write_i.addr] <= write_i.data;
        end
    end

    // registered reads see the old contents on a same-cycle write
    always_ff @(posedge clk_i) begin
        rd_data_1_o <= mem[rd_addr_1_i];
        rd_data_2_o <= mem[rd_addr_2_i];
    end

    // the PC lives outside the array, the execute stage must filter these writes
    pc_never_written: assert property (
        @(posedge clk_i) write_i.enable |-> (write_i.addr != `PC_REG)
    ) else $error("write to the PC register reached the register RAM");

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+design
design/reg_pkg.sv
design/op_pkg.sv
design/reg_ram.sv
design/clocked_reg_file.sv
design/alu_stage.sv
design/exec_core.sv
bench/exec_core_tb.sv
